// File: source/hist_cfg_pkg.sv
`default_nettype none

package hist_cfg_pkg;

    // ****************************************
    // bin memory geometry
    // ****************************************

    // width of a time bin address.
    localparam int unsigned BIN_ADDR_W = 4;

    // number of time bins per pixel histogram.
    localparam int unsigned BIN_NUM = 16;

    // width of one bin counter.
    localparam int unsigned COUNT_W = 8;

    // a bin holds at this value once reached.
    localparam logic [COUNT_W-1:0] COUNT_MAX = '1;

    // width of the summed count over all bins, wide enough for BIN_NUM saturated bins.
    localparam int unsigned TOTAL_W = 12;

    // ****************************************
    // frame sequencing
    // ****************************************

    // acquisitions summed into one pixel histogram.
    localparam int unsigned ACQ_NUM = 4;
    localparam int unsigned ACQ_W = 2;

    // pixels per frame before the index wraps.
    localparam int unsigned PIXEL_NUM = 3;
    localparam int unsigned PIXEL_W = 2;

    // cycles spent in drain so the increment pipeline empties.
    localparam int unsigned DRAIN_NUM = 2;
    localparam int unsigned DRAIN_W = 1;

endpackage

`default_nettype wire

// File: source/hist_types_pkg.sv
`default_nettype none

package hist_types_pkg;

    import hist_cfg_pkg::*;

    // ****************************************
    // interface payloads
    // ****************************************

    // one detector event, last_of_acq closes the current acquisition.
    typedef struct packed {
        logic [BIN_ADDR_W-1:0] bin_addr;
        logic                  last_of_acq;
    } tdc_event_t;

    // per pixel report produced after the scan.
    typedef struct packed {
        logic [PIXEL_W-1:0]    pixel;
        logic [BIN_ADDR_W-1:0] peak_bin;
        logic [COUNT_W-1:0]    peak_count;
        logic [TOTAL_W-1:0]    total;
    } hist_result_t;

    // ****************************************
    // controller states
    // ****************************************

    typedef enum logic [2:0] {
        ST_CLEAR  = 3'd0,
        ST_ACCUM  = 3'd1,
        ST_DRAIN  = 3'd2,
        ST_SCAN   = 3'd3,
        ST_REPORT = 3'd4
    } builder_state_t;

endpackage

`default_nettype wire

// File: source/bin_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bin_ram (
    input  wire                                  clk,
    input  wire                                  res,
    input  wire                                  clear,
    input  wire  [hist_cfg_pkg::BIN_ADDR_W-1:0]  clear_addr,
    input  wire                                  inc,
    input  wire  [hist_cfg_pkg::BIN_ADDR_W-1:0]  inc_addr,
    input  wire                                  scan_rd,
    input  wire  [hist_cfg_pkg::BIN_ADDR_W-1:0]  scan_addr,
    output logic [hist_cfg_pkg::COUNT_W-1:0]     scan_count
);

    import hist_cfg_pkg::*;

    logic [COUNT_W-1:0]    count_mem [BIN_NUM];

    // write stage of the increment pipeline.
    logic                  wr_valid;
    logic [BIN_ADDR_W-1:0] wr_addr;
    logic [COUNT_W-1:0]    wr_data;

    logic [COUNT_W-1:0]    rd_count;
    logic [COUNT_W-1:0]    next_count;

    // ****************************************
    // read stage
    // ****************************************

    // the write stage still holds the newest value of its bin, so a hit
    // on the same address takes it from there instead of the array.
    always_comb begin
        if (wr_valid && (wr_addr == inc_addr)) begin
            rd_count = wr_data;
        end else begin
            rd_count = count_mem[inc_addr];
        end

        if (rd_count == COUNT_MAX) begin
            next_count = rd_count;
        end else begin
            next_count = rd_count + 1'b1;
        end
    end

    // ****************************************
    // write stage and ports
    // ****************************************

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= inc;
        end
    end

    always_ff @(posedge clk) begin
        if (inc) begin
            wr_addr <= inc_addr;
            wr_data <= next_count;
        end

        if (clear) begin
            count_mem[clear_addr] <= '0;
        end else if (wr_valid) begin
            count_mem[wr_addr] <= wr_data;
        end

        if (scan_rd) begin
            scan_count <= count_mem[scan_addr];
        end
    end

    // the controller runs clear, accumulate and scan as separate phases.
    a_one_access: assert property (
        @(posedge clk) disable iff (!res)
        $onehot0({clear, inc, scan_rd})
    );

endmodule

`default_nettype wire

// File: source/peak_search.sv
`timescale 1ns/1ps
`default_nettype none

module peak_search (
    input  wire                                  clk,
    input  wire                                  res,
    input  wire                                  start,
    input  wire                                  bin_valid,
    input  wire  [hist_cfg_pkg::COUNT_W-1:0]     count,
    output logic [hist_cfg_pkg::BIN_ADDR_W-1:0]  peak_bin,
    output logic [hist_cfg_pkg::COUNT_W-1:0]     peak_count,
    output logic [hist_cfg_pkg::TOTAL_W-1:0]     total
);

    import hist_cfg_pkg::*;

    // bins arrive in address order, so a local counter names them.
    logic [BIN_ADDR_W-1:0] bin_idx;

    // ****************************************
    // running maximum and sum
    // ****************************************

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bin_idx    <= '0;
            peak_bin   <= '0;
            peak_count <= '0;
            total      <= '0;
        end else if (start) begin
            bin_idx    <= '0;
            peak_bin   <= '0;
            peak_count <= '0;
            total      <= '0;
        end else if (bin_valid) begin
            bin_idx <= bin_idx + 1'b1;
            total   <= total + TOTAL_W'(count);

            // strictly larger only, an equal count later on keeps the earlier bin.
            if (count > peak_count) begin
                peak_count <= count;
                peak_bin   <= bin_idx;
            end
        end
    end

    // a restart in the middle of a scan would mix two pixels.
    a_start_apart: assert property (
        @(posedge clk) disable iff (!res)
        start |-> !bin_valid
    );

endmodule

`default_nettype wire

// File: source/hist_builder_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder_fsm (
    input  wire                                  clk,
    input  wire                                  res,
    input  wire                                  event_valid,
    output logic                                 event_ready,
    input  wire  hist_types_pkg::tdc_event_t     event_data,
    output logic                                 result_valid,
    input  wire                                  result_ready,
    output hist_types_pkg::hist_result_t         result,
    output logic                                 ram_clear,
    output logic [hist_cfg_pkg::BIN_ADDR_W-1:0]  ram_clear_addr,
    output logic                                 ram_inc,
    output logic [hist_cfg_pkg::BIN_ADDR_W-1:0]  ram_inc_addr,
    output logic                                 ram_scan_rd,
    output logic [hist_cfg_pkg::BIN_ADDR_W-1:0]  ram_scan_addr,
    output logic                                 search_start,
    output logic                                 search_bin_valid,
    input  wire  [hist_cfg_pkg::BIN_ADDR_W-1:0]  peak_bin,
    input  wire  [hist_cfg_pkg::COUNT_W-1:0]     peak_count,
    input  wire  [hist_cfg_pkg::TOTAL_W-1:0]     peak_total
);

    import hist_cfg_pkg::*;
    import hist_types_pkg::*;

    builder_state_t        state;

    // shared by clear and scan, both walk the bins from 0 upwards.
    logic [BIN_ADDR_W-1:0] addr_cnt;
    logic [ACQ_W-1:0]      acq_cnt;
    logic [DRAIN_W-1:0]    drain_cnt;
    logic [PIXEL_W-1:0]    pixel;

    // set once the last bin is read, covering the read latency of bin_ram.
    logic                  scan_done;
    logic                  accept;

    assign accept = event_valid && event_ready;

    // ****************************************
    // sequencing
    // ****************************************

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state            <= ST_CLEAR;
            addr_cnt         <= '0;
            acq_cnt          <= '0;
            drain_cnt        <= '0;
            pixel            <= '0;
            scan_done        <= 1'b0;
            event_ready      <= 1'b0;
            search_bin_valid <= 1'b0;
        end else begin
            search_bin_valid <= ram_scan_rd;

            case (state)
                ST_CLEAR: begin
                    addr_cnt <= addr_cnt + 1'b1;
                    if (addr_cnt == BIN_ADDR_W'(BIN_NUM - 1)) begin
                        state       <= ST_ACCUM;
                        event_ready <= 1'b1;
                    end
                end

                ST_ACCUM: begin
                    if (accept && event_data.last_of_acq) begin
                        acq_cnt <= acq_cnt + 1'b1;
                        if (acq_cnt == ACQ_W'(ACQ_NUM - 1)) begin
                            state       <= ST_DRAIN;
                            event_ready <= 1'b0;
                        end
                    end
                end

                ST_DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_W'(DRAIN_NUM - 1)) begin
                        drain_cnt <= '0;
                        state     <= ST_SCAN;
                    end
                end

                ST_SCAN: begin
                    if (scan_done) begin
                        scan_done <= 1'b0;
                        state     <= ST_REPORT;
                    end else begin
                        addr_cnt <= addr_cnt + 1'b1;
                        if (addr_cnt == BIN_ADDR_W'(BIN_NUM - 1)) begin
                            scan_done <= 1'b1;
                        end
                    end
                end

                ST_REPORT: begin
                    if (result_ready) begin
                        if (pixel == PIXEL_W'(PIXEL_NUM - 1)) begin
                            pixel <= '0;
                        end else begin
                            pixel <= pixel + 1'b1;
                        end
                        state <= ST_CLEAR;
                    end
                end

                default: begin
                    state <= ST_CLEAR;
                end
            endcase
        end
    end

    // ****************************************
    // memory and search control
    // ****************************************

    assign ram_clear      = (state == ST_CLEAR);
    assign ram_clear_addr = addr_cnt;
    assign ram_inc        = accept;
    assign ram_inc_addr   = event_data.bin_addr;
    assign ram_scan_rd    = (state == ST_SCAN) && !scan_done;
    assign ram_scan_addr  = addr_cnt;

    // peak_search restarts in the first drain cycle, well before the first scan data.
    assign search_start = (state == ST_DRAIN) && (drain_cnt == '0);

    assign result_valid      = (state == ST_REPORT);
    assign result.pixel      = pixel;
    assign result.peak_bin   = peak_bin;
    assign result.peak_count = peak_count;
    assign result.total      = peak_total;

    // the peak search must not move while a report waits.
    a_result_hold: assert property (
        @(posedge clk) disable iff (!res)
        result_valid && !result_ready |=> result_valid && $stable(result)
    );

    a_ready_in_accum: assert property (
        @(posedge clk) disable iff (!res)
        event_ready |-> state == ST_ACCUM
    );

endmodule

`default_nettype wire

// File: source/hist_top.sv
`timescale 1ns/1ps
`default_nettype none

module hist_top (
    input  wire                              clk,
    input  wire                              res,
    input  wire                              event_valid,
    output logic                             event_ready,
    input  wire  hist_types_pkg::tdc_event_t event_data,
    output logic                             result_valid,
    input  wire                              result_ready,
    output hist_types_pkg::hist_result_t     result
);

    import hist_cfg_pkg::*;

    logic                  ram_clear;
    logic [BIN_ADDR_W-1:0] ram_clear_addr;
    logic                  ram_inc;
    logic [BIN_ADDR_W-1:0] ram_inc_addr;
    logic                  ram_scan_rd;
    logic [BIN_ADDR_W-1:0] ram_scan_addr;
    logic [COUNT_W-1:0]    scan_count;

    logic                  search_start;
    logic                  search_bin_valid;
    logic [BIN_ADDR_W-1:0] peak_bin;
    logic [COUNT_W-1:0]    peak_count;
    logic [TOTAL_W-1:0]    peak_total;

    hist_builder_fsm u_hist_builder_fsm (
        .clk              (clk),
        .res              (res),
        .event_valid      (event_valid),
        .event_ready      (event_ready),
        .event_data       (event_data),
        .result_valid     (result_valid),
        .result_ready     (result_ready),
        .result           (result),
        .ram_clear        (ram_clear),
        .ram_clear_addr   (ram_clear_addr),
        .ram_inc          (ram_inc),
        .ram_inc_addr     (ram_inc_addr),
        .ram_scan_rd      (ram_scan_rd),
        .ram_scan_addr    (ram_scan_addr),
        .search_start     (search_start),
        .search_bin_valid (search_bin_valid),
        .peak_bin         (peak_bin),
        .peak_count       (peak_count),
        .peak_total       (peak_total)
    );

    bin_ram u_bin_ram (
        .clk        (clk),
        .res        (res),
        .clear      (ram_clear),
        .clear_addr (ram_clear_addr),
        .inc        (ram_inc),
        .inc_addr   (ram_inc_addr),
        .scan_rd    (ram_scan_rd),
        .scan_addr  (ram_scan_addr),
        .scan_count (scan_count)
    );

    peak_search u_peak_search (
        .clk        (clk),
        .res        (res),
        .start      (search_start),
        .bin_valid  (search_bin_valid),
        .count      (scan_count),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .total      (peak_total)
    );

endmodule

`default_nettype wire

// File: test/tb_hist_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hist_top;

    import hist_cfg_pkg::*;
    import hist_types_pkg::*;

    localparam int unsigned COUNT_LIMIT    = (1 << COUNT_W) - 1;
    localparam int          FRAME_NUM      = 5;
    localparam int          READY_TIMEOUT  = 1000;
    localparam int          RESULT_TIMEOUT = 5000;

    logic         clk;
    logic         res;
    logic         event_valid;
    logic         event_ready;
    tdc_event_t   event_data;
    logic         result_valid;
    logic         result_ready;
    hist_result_t result;

    // accepted bins of the frame in progress, and the results still to come.
    int unsigned  accepted_bins[$];
    hist_result_t expected_q[$];
    string        name_q[$];
    int           frame_idx;
    int           results_checked;

    hist_top u_hist_top (
        .clk          (clk),
        .res          (res),
        .event_valid  (event_valid),
        .event_ready  (event_ready),
        .event_data   (event_data),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ****************************************
    // helpers
    // ****************************************

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input int expected, input int actual);
        stop_with_error($sformatf("[FAIL] %s %s expected %0d actual %0d",
                                  test, field, expected, actual));
    endtask

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic send_event(input int unsigned bin, input bit last);
        int wait_cycles;
        wait_cycles = 0;
        event_valid = 1'b1;
        event_data.bin_addr = BIN_ADDR_W'(bin);
        event_data.last_of_acq = last;
        while (!event_ready) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > READY_TIMEOUT) begin
                stop_with_error("event_ready never rose while an event was waiting");
            end
        end
        @(negedge clk);
        event_valid = 1'b0;
        accepted_bins.push_back(bin);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // saturating bin counts, strict maximum so the lowest bin wins a tie.
    function automatic hist_result_t expected_result(input int frame);
        int unsigned  counts [BIN_NUM];
        int unsigned  sum;
        hist_result_t exp_res;
        foreach (counts[b]) begin
            counts[b] = 0;
        end
        sum = 0;
        exp_res = '0;
        foreach (accepted_bins[i]) begin
            if (counts[accepted_bins[i]] < COUNT_LIMIT) begin
                counts[accepted_bins[i]]++;
            end
        end
        for (int b = 0; b < BIN_NUM; b++) begin
            sum += counts[b];
            if (counts[b] > exp_res.peak_count) begin
                exp_res.peak_count = COUNT_W'(counts[b]);
                exp_res.peak_bin   = BIN_ADDR_W'(b);
            end
        end
        exp_res.total = TOTAL_W'(sum);
        exp_res.pixel = PIXEL_W'(frame % PIXEL_NUM);
        return exp_res;
    endfunction

    task automatic finish_frame(input string name);
        expected_q.push_back(expected_result(frame_idx));
        name_q.push_back(name);
        accepted_bins.delete();
        frame_idx++;
    endtask

    // ****************************************
    // frames
    // ****************************************

    task automatic single_bin_frame();
        for (int acq = 0; acq < ACQ_NUM; acq++) begin
            for (int i = 0; i < 6; i++) begin
                send_event(5, i == 5);
            end
        end
        finish_frame("single_bin");
    endtask

    task automatic random_frame();
        int len;
        for (int acq = 0; acq < ACQ_NUM; acq++) begin
            len = $urandom_range(20, 1);
            for (int i = 0; i < len; i++) begin
                idle($urandom_range(3));
                send_event($urandom % BIN_NUM, i == len - 1);
            end
        end
        finish_frame("random_accum");
    endtask

    // a stale bin 5 from the first pixel 0 frame would show up here.
    task automatic saturation_frame();
        for (int i = 0; i < 5; i++) begin
            send_event(2, 1'b0);
        end
        for (int acq = 0; acq < ACQ_NUM; acq++) begin
            for (int i = 0; i < 75; i++) begin
                send_event(9, i == 74);
            end
        end
        finish_frame("saturation_wrap");
    endtask

    task automatic tie_frame();
        int unsigned pattern [6] = '{11, 3, 0, 11, 3, 7};
        for (int acq = 0; acq < ACQ_NUM; acq++) begin
            for (int i = 0; i < 6; i++) begin
                send_event(pattern[i], i == 5);
            end
        end
        finish_frame("tie");
    endtask

    // ****************************************
    // stimulus
    // ****************************************

    initial begin : stimulus
        int wait_cycles;
        void'($urandom(32'h21c4));
        frame_idx = 0;
        res = 1'b0;
        event_valid = 1'b0;
        event_data = '0;
        repeat (4) begin
            @(negedge clk);
            assert (!event_ready && !result_valid) else
                stop_with_error("event_ready or result_valid was high during reset");
        end
        res = 1'b1;
        @(negedge clk);
        assert (!event_ready) else
            stop_with_error("event_ready rose before the bin memory was cleared");

        single_bin_frame();
        random_frame();
        random_frame();
        saturation_frame();
        tie_frame();

        wait_cycles = 0;
        while (results_checked < FRAME_NUM) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESULT_TIMEOUT) begin
                stop_with_error("the last results never arrived");
            end
        end
        idle(4);
        if (results_checked == FRAME_NUM && expected_q.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1);
        end
    end

    // ****************************************
    // result compare
    // ****************************************

    initial begin : compare
        hist_result_t got;
        hist_result_t exp_res;
        string        name;
        int           wait_cycles;
        int           hold;
        result_ready = 1'b0;
        results_checked = 0;
        forever begin
            wait_cycles = 0;
            @(negedge clk);
            while (!result_valid) begin
                @(negedge clk);
                wait_cycles++;
                if (wait_cycles > RESULT_TIMEOUT) begin
                    stop_with_error("result_valid never rose after a pixel was sent");
                end
            end
            got = result;
            hold = $urandom_range(5);
            repeat (hold) begin
                @(negedge clk);
                assert (result_valid && result == got) else
                    stop_with_error("result changed or dropped before its handshake");
            end
            result_ready = 1'b1;
            @(negedge clk);
            result_ready = 1'b0;

            assert (expected_q.size() > 0) else
                stop_with_error("a result arrived with no pixel pending");
            exp_res = expected_q.pop_front();
            name = name_q.pop_front();
            assert (got.pixel == exp_res.pixel) else
                report_mismatch(name, "pixel", exp_res.pixel, got.pixel);
            assert (got.peak_bin == exp_res.peak_bin) else
                report_mismatch(name, "peak_bin", exp_res.peak_bin, got.peak_bin);
            assert (got.peak_count == exp_res.peak_count) else
                report_mismatch(name, "peak_count", exp_res.peak_count, got.peak_count);
            assert (got.total == exp_res.total) else
                report_mismatch(name, "total", exp_res.total, got.total);
            assert (!result_valid) else
                stop_with_error("result_valid stayed high after the handshake");
            results_checked++;
        end
    end

endmodule

`default_nettype wire

// File: all.f
source/hist_cfg_pkg.sv
source/hist_types_pkg.sv
source/bin_ram.sv
source/peak_search.sv
source/hist_builder_fsm.sv
source/hist_top.sv
test/tb_hist_top.sv

// File: Bender.yml
package:
  name: hist_top

sources:
  - source/hist_cfg_pkg.sv
  - source/hist_types_pkg.sv
  - source/bin_ram.sv
  - source/peak_search.sv
  - source/hist_builder_fsm.sv
  - source/hist_top.sv
  - target: test
    files:
      - test/tb_hist_top.sv
